/* common/sldu_pkg.sv */
// Shared widths and data types of the vector slide unit
// Lane word layout and element width codes

package sldu_pkg;

  // Number of instruction ids the sequencer hands out
  localparam int unsigned NrVInsn = 8;

  // One lane word is 64 bits
  localparam int unsigned ElenBytes = 8;
  localparam int unsigned Elen      = 8 * ElenBytes;

  // Lane data word and its byte enables
  typedef logic [Elen-1:0]      elen_t;
  typedef logic [ElenBytes-1:0] strb_t;

  // Instruction id
  typedef logic [$clog2(NrVInsn)-1:0] vid_t;

  // Vector length, offset or byte count
  typedef logic [15:0] vlen_t;

  // Destination word address in the register file
  typedef logic [9:0] vaddr_t;

  // Element width code
  // Element size in bytes is 1 << code
  typedef logic [1:0] sew_t;

  localparam sew_t EW8  = 2'd0;
  localparam sew_t EW16 = 2'd1;
  localparam sew_t EW32 = 2'd2;
  localparam sew_t EW64 = 2'd3;

endpackage

/* run_sim.sh */
#!/bin/sh
# Build the slide unit testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_sldu -f tb.f -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/Vtb_sldu > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Simulation completed successfully" "$LOG"; then
  exit 0
fi
echo "Pass message not found in $LOG"
exit 1

/* sldu/sldu_decode.sv */
`timescale 1ns/1ps
// Instruction queue of the slide unit
// Accepts requests, scales the slide offset to bytes, presents the oldest
// unissued instruction to the slide engine and reports finished ids

module sldu_decode #(
  parameter int unsigned InsnQueueDepth = 4
) (
  input  logic             clk_i,
  input  logic             rst_ni,
  // Request channel from the sequencer
  input  logic             req_valid_i,
  output logic             req_ready_o,
  input  sldu_pkg::vid_t   req_id_i,
  input  logic             req_up_i,
  input  sldu_pkg::vaddr_t req_vd_i,
  input  sldu_pkg::vlen_t  req_vl_i,
  input  sldu_pkg::vlen_t  req_stride_i,
  input  sldu_pkg::sew_t   req_sew_i,
  // Issue port towards the slide engine
  output logic             issue_valid_o,
  output sldu_pkg::vid_t   issue_id_o,
  output logic             issue_up_o,
  output sldu_pkg::vaddr_t issue_vd_o,
  output sldu_pkg::vlen_t  issue_off_o,
  output sldu_pkg::vlen_t  issue_bytes_o,
  input  logic             issue_done_i,
  // Last word of an instruction left the result queue
  input  logic             commit_valid_i,
  input  sldu_pkg::vid_t   commit_id_i,
  // Done report
  output logic             done_o,
  output sldu_pkg::vid_t   done_id_o
);

  import sldu_pkg::*;

  localparam int unsigned PntW = $clog2(InsnQueueDepth);
  localparam int unsigned CntW = $clog2(InsnQueueDepth + 1);

  typedef logic [PntW-1:0] pnt_t;
  typedef logic [CntW-1:0] cnt_t;

  //////////////////////////////////////////////////////////////////////
  // Queue storage
  //////////////////////////////////////////////////////////////////////

  // One entry per in-flight instruction, offset and count in bytes
  vid_t   insn_id_q    [InsnQueueDepth];
  logic   insn_up_q    [InsnQueueDepth];
  vaddr_t insn_vd_q    [InsnQueueDepth];
  vlen_t  insn_off_q   [InsnQueueDepth];
  vlen_t  insn_bytes_q [InsnQueueDepth];

  // Accept and issue phase pointers
  pnt_t accept_pnt_q, issue_pnt_q;
  // Entries waiting for issue, entries not yet committed
  cnt_t issue_cnt_q, commit_cnt_q;

  logic  accept;
  vlen_t req_off;
  vlen_t req_total;

  // Circular increment, depth need not be a power of two
  function automatic pnt_t next_pnt(input pnt_t pnt);
    return (pnt == pnt_t'(InsnQueueDepth - 1)) ? '0 : pnt + 1'b1;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Accept phase
  //////////////////////////////////////////////////////////////////////

  // Full once every entry waits for its commit
  assign req_ready_o = (commit_cnt_q != cnt_t'(InsnQueueDepth));
  assign accept      = req_valid_i && req_ready_o;

  // Slide offset and vector size in bytes
  assign req_off   = req_stride_i << req_sew_i;
  assign req_total = req_vl_i << req_sew_i;

  always_ff @(posedge clk_i) begin
    if (accept) begin
      insn_id_q[accept_pnt_q] <= req_id_i;
      insn_up_q[accept_pnt_q] <= req_up_i;
      insn_vd_q[accept_pnt_q] <= req_vd_i;
      insn_off_q[accept_pnt_q] <= req_off;
      // Slide-up leaves the bytes below the offset untouched
      insn_bytes_q[accept_pnt_q] <= req_up_i ? (req_total - req_off) : req_total;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Issue and commit phases
  //////////////////////////////////////////////////////////////////////

  assign issue_valid_o = (issue_cnt_q != '0);
  assign issue_id_o    = insn_id_q[issue_pnt_q];
  assign issue_up_o    = insn_up_q[issue_pnt_q];
  assign issue_vd_o    = insn_vd_q[issue_pnt_q];
  assign issue_off_o   = insn_off_q[issue_pnt_q];
  assign issue_bytes_o = insn_bytes_q[issue_pnt_q];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      accept_pnt_q <= '0;
      issue_pnt_q  <= '0;
      issue_cnt_q  <= '0;
      commit_cnt_q <= '0;
      done_o       <= 1'b0;
    end else begin
      if (accept) begin
        accept_pnt_q <= next_pnt(accept_pnt_q);
      end
      // Engine finished the head instruction
      if (issue_done_i) begin
        issue_pnt_q <= next_pnt(issue_pnt_q);
      end
      issue_cnt_q  <= issue_cnt_q + cnt_t'(accept) - cnt_t'(issue_done_i);
      // Commits arrive in order, so the oldest entry is freed
      commit_cnt_q <= commit_cnt_q + cnt_t'(accept) - cnt_t'(commit_valid_i);
      done_o       <= commit_valid_i;
    end
  end

  // Id of the committed instruction, valid with done_o
  always_ff @(posedge clk_i) begin
    if (commit_valid_i) begin
      done_id_o <= commit_id_i;
    end
  end

endmodule

/* sldu/sldu_execute.sv */
`timescale 1ns/1ps
// Slide engine of the slide unit
// Moves source bytes from operand words into destination words by
// byte pointers and pushes finished words into the result queue

module sldu_execute #(
  parameter int unsigned NrLanes = 4
) (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  // Instruction from the queue
  input  logic                            issue_valid_i,
  input  sldu_pkg::vid_t                  issue_id_i,
  input  logic                            issue_up_i,
  input  sldu_pkg::vaddr_t                issue_vd_i,
  input  sldu_pkg::vlen_t                 issue_off_i,
  input  sldu_pkg::vlen_t                 issue_bytes_i,
  output logic                            issue_done_o,
  // Source operand words from the lanes
  input  sldu_pkg::elen_t   [NrLanes-1:0] operand_i,
  input  logic                            operand_valid_i,
  output logic                            operand_ready_o,
  // Destination words towards the result queue
  output logic                            push_valid_o,
  input  logic                            push_ready_i,
  output sldu_pkg::vid_t                  push_id_o,
  output sldu_pkg::vaddr_t                push_addr_o,
  output sldu_pkg::elen_t   [NrLanes-1:0] push_wdata_o,
  output sldu_pkg::strb_t   [NrLanes-1:0] push_be_o,
  output logic                            push_last_o
);

  import sldu_pkg::*;

  // Bytes in one full word across all lanes
  localparam int unsigned WordBytes = NrLanes * ElenBytes;
  localparam int unsigned OffW      = $clog2(WordBytes);
  localparam int unsigned PntW      = OffW + 1;

  typedef logic [PntW-1:0]        pnt_t;
  typedef logic [WordBytes-1:0]   byte_mask_t;
  typedef logic [8*WordBytes-1:0] word_t;

  typedef enum logic {
    SLIDE_IDLE,
    SLIDE_RUN
  } slide_state_e;

  slide_state_e state_d, state_q;

  // Byte pointers into the operand word and the destination word
  pnt_t   in_pnt_d, in_pnt_q;
  pnt_t   out_pnt_d, out_pnt_q;
  // Destination word address
  vaddr_t vrf_pnt_d, vrf_pnt_q;
  // Bytes still to move
  vlen_t  cnt_d, cnt_q;
  vid_t   id_q;

  // Word under assembly and its enables
  word_t      word_q, word_asm;
  byte_mask_t be_d, be_q, be_asm;

  logic               step;
  logic               last_step;
  pnt_t               in_avail, out_avail, cnt_avail, n;
  word_t              shifted;
  logic [WordBytes:0] win_full;
  byte_mask_t         win;

  //////////////////////////////////////////////////////////////////////
  // Byte mover
  //////////////////////////////////////////////////////////////////////

  // Advance only with an operand and room in the result queue
  assign step = (state_q == SLIDE_RUN) && operand_valid_i && push_ready_i;

  // Bytes left in each word and in the instruction
  assign in_avail  = pnt_t'(WordBytes) - in_pnt_q;
  assign out_avail = pnt_t'(WordBytes) - out_pnt_q;
  assign cnt_avail = (cnt_q < vlen_t'(WordBytes)) ? pnt_t'(cnt_q) : pnt_t'(WordBytes);

  // Smallest of the three
  always_comb begin
    n = (in_avail < out_avail) ? in_avail : out_avail;
    if (cnt_avail < n) begin
      n = cnt_avail;
    end
  end

  assign last_step = (cnt_q == vlen_t'(n));

  // Align the source byte at in_pnt with the destination byte at out_pnt
  assign shifted = (word_t'(operand_i) >> {in_pnt_q, 3'b000}) << {out_pnt_q, 3'b000};

  // n enabled bytes starting at out_pnt
  assign win_full = ({{WordBytes{1'b0}}, 1'b1} << n) - 1'b1;
  assign win      = win_full[WordBytes-1:0] << out_pnt_q;

  always_comb begin
    word_asm = word_q;
    for (int b = 0; b < WordBytes; b++) begin
      if (win[b]) begin
        word_asm[8*b +: 8] = shifted[8*b +: 8];
      end
    end
  end

  assign be_asm = be_q | win;

  // Pushed word is the one assembled in this step
  assign push_wdata_o = word_asm;
  assign push_be_o    = be_asm;
  assign push_id_o    = id_q;
  assign push_addr_o  = vrf_pnt_q;

  //////////////////////////////////////////////////////////////////////
  // Slide FSM
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d   = state_q;
    in_pnt_d  = in_pnt_q;
    out_pnt_d = out_pnt_q;
    vrf_pnt_d = vrf_pnt_q;
    cnt_d     = cnt_q;
    be_d      = be_q;

    operand_ready_o = 1'b0;
    push_valid_o    = 1'b0;
    push_last_o     = 1'b0;
    issue_done_o    = 1'b0;

    unique case (state_q)
      SLIDE_IDLE: begin
        if (issue_valid_i) begin
          state_d = SLIDE_RUN;
          cnt_d   = issue_bytes_i;
          if (issue_up_i) begin
            // Read from byte 0, write from the offset
            in_pnt_d  = '0;
            out_pnt_d = pnt_t'(issue_off_i[OffW-1:0]);
            vrf_pnt_d = issue_vd_i + vaddr_t'(issue_off_i >> OffW);
          end else begin
            // First source word is picked by the lanes, start inside it
            in_pnt_d  = pnt_t'(issue_off_i[OffW-1:0]);
            out_pnt_d = '0;
            vrf_pnt_d = issue_vd_i;
          end
        end
      end
      SLIDE_RUN: begin
        if (step) begin
          in_pnt_d  = in_pnt_q + n;
          out_pnt_d = out_pnt_q + n;
          cnt_d     = cnt_q - vlen_t'(n);
          be_d      = be_asm;

          // Operand word used up, or instruction over
          if (in_pnt_d == pnt_t'(WordBytes) || last_step) begin
            in_pnt_d        = '0;
            operand_ready_o = 1'b1;
          end

          // Destination word full, or instruction over
          if (out_pnt_d == pnt_t'(WordBytes) || last_step) begin
            out_pnt_d    = '0;
            vrf_pnt_d    = vrf_pnt_q + 1'b1;
            be_d         = '0;
            push_valid_o = 1'b1;
            push_last_o  = last_step;
          end

          if (last_step) begin
            state_d      = SLIDE_IDLE;
            issue_done_o = 1'b1;
          end
        end
      end
      default: state_d = SLIDE_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q   <= SLIDE_IDLE;
      in_pnt_q  <= '0;
      out_pnt_q <= '0;
      vrf_pnt_q <= '0;
      cnt_q     <= '0;
      be_q      <= '0;
    end else begin
      state_q   <= state_d;
      in_pnt_q  <= in_pnt_d;
      out_pnt_q <= out_pnt_d;
      vrf_pnt_q <= vrf_pnt_d;
      cnt_q     <= cnt_d;
      be_q      <= be_d;
    end
  end

  // Payload of the running instruction
  always_ff @(posedge clk_i) begin
    if (state_q == SLIDE_IDLE && issue_valid_i) begin
      id_q <= issue_id_i;
    end
    if (step) begin
      word_q <= word_asm;
    end
  end

endmodule

/* sldu/sldu_result.sv */
`timescale 1ns/1ps
// Two-entry result queue of the slide unit
// Holds destination words until the register file takes them and
// reports the commit of the last word of each instruction

module sldu_result #(
  parameter int unsigned NrLanes = 4
) (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  // Words from the slide engine
  input  logic                            push_valid_i,
  output logic                            push_ready_o,
  input  sldu_pkg::vid_t                  push_id_i,
  input  sldu_pkg::vaddr_t                push_addr_i,
  input  sldu_pkg::elen_t   [NrLanes-1:0] push_wdata_i,
  input  sldu_pkg::strb_t   [NrLanes-1:0] push_be_i,
  input  logic                            push_last_i,
  // Result channel to the register file
  output logic                            res_valid_o,
  input  logic                            res_ready_i,
  output sldu_pkg::vid_t                  res_id_o,
  output sldu_pkg::vaddr_t                res_addr_o,
  output sldu_pkg::elen_t   [NrLanes-1:0] res_wdata_o,
  output sldu_pkg::strb_t   [NrLanes-1:0] res_be_o,
  // Last word of an instruction accepted
  output logic                            commit_valid_o,
  output sldu_pkg::vid_t                  commit_id_o
);

  import sldu_pkg::*;

  localparam int unsigned Depth = 2;

  typedef elen_t [NrLanes-1:0] word_t;
  typedef strb_t [NrLanes-1:0] be_t;

  // Entry storage
  vid_t   id_q    [Depth];
  vaddr_t addr_q  [Depth];
  word_t  wdata_q [Depth];
  be_t    be_q    [Depth];
  logic   last_q  [Depth];

  logic       wr_pnt_q, rd_pnt_q;
  logic [1:0] cnt_q;
  logic       push, pop;

  assign push_ready_o = (cnt_q != 2'(Depth));
  assign push         = push_valid_i && push_ready_o;

  assign res_valid_o = (cnt_q != '0);
  assign pop         = res_valid_o && res_ready_i;

  // Head entry drives the result channel
  assign res_id_o    = id_q[rd_pnt_q];
  assign res_addr_o  = addr_q[rd_pnt_q];
  assign res_wdata_o = wdata_q[rd_pnt_q];
  assign res_be_o    = be_q[rd_pnt_q];

  // Commit on the handshake of a last word
  assign commit_valid_o = pop && last_q[rd_pnt_q];
  assign commit_id_o    = id_q[rd_pnt_q];

  always_ff @(posedge clk_i) begin
    if (push) begin
      id_q[wr_pnt_q]    <= push_id_i;
      addr_q[wr_pnt_q]  <= push_addr_i;
      wdata_q[wr_pnt_q] <= push_wdata_i;
      be_q[wr_pnt_q]    <= push_be_i;
      last_q[wr_pnt_q]  <= push_last_i;
    end
  end

  // Pointers wrap naturally with two entries
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_pnt_q <= 1'b0;
      rd_pnt_q <= 1'b0;
      cnt_q    <= '0;
    end else begin
      if (push) begin
        wr_pnt_q <= ~wr_pnt_q;
      end
      if (pop) begin
        rd_pnt_q <= ~rd_pnt_q;
      end
      cnt_q <= cnt_q + 2'(push) - 2'(pop);
    end
  end

endmodule

/* sldu/sldu_top.sv */
`timescale 1ns/1ps
// Top level of the vector slide unit
// Instruction queue, slide engine and result queue

module sldu_top #(
  parameter int unsigned NrLanes        = 4,
  parameter int unsigned InsnQueueDepth = 4
) (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  // Request channel
  input  logic                            req_valid_i,
  input  sldu_pkg::vid_t                  req_id_i,
  input  logic                            req_up_i,
  input  sldu_pkg::vaddr_t                req_vd_i,
  input  sldu_pkg::vlen_t                 req_vl_i,
  input  sldu_pkg::vlen_t                 req_stride_i,
  input  sldu_pkg::sew_t                  req_sew_i,
  output logic                            req_ready_o,
  // Operand channel
  input  logic                            operand_valid_i,
  input  sldu_pkg::elen_t   [NrLanes-1:0] operand_i,
  output logic                            operand_ready_o,
  // Result channel
  output logic                            res_valid_o,
  output sldu_pkg::vid_t                  res_id_o,
  output sldu_pkg::vaddr_t                res_addr_o,
  output sldu_pkg::elen_t   [NrLanes-1:0] res_wdata_o,
  output sldu_pkg::strb_t   [NrLanes-1:0] res_be_o,
  input  logic                            res_ready_i,
  // Done report
  output logic                            done_o,
  output sldu_pkg::vid_t                  done_id_o
);

  import sldu_pkg::*;

  // Queue to engine
  logic   issue_valid, issue_up, issue_done;
  vid_t   issue_id;
  vaddr_t issue_vd;
  vlen_t  issue_off, issue_bytes;

  // Engine to result queue
  logic                push_valid, push_ready, push_last;
  vid_t                push_id;
  vaddr_t              push_addr;
  elen_t [NrLanes-1:0] push_wdata;
  strb_t [NrLanes-1:0] push_be;

  // Result queue back to the instruction queue
  logic commit_valid;
  vid_t commit_id;

  sldu_decode #(
    .InsnQueueDepth(InsnQueueDepth)
  ) i_decode (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .req_valid_i   (req_valid_i),
    .req_ready_o   (req_ready_o),
    .req_id_i      (req_id_i),
    .req_up_i      (req_up_i),
    .req_vd_i      (req_vd_i),
    .req_vl_i      (req_vl_i),
    .req_stride_i  (req_stride_i),
    .req_sew_i     (req_sew_i),
    .issue_valid_o (issue_valid),
    .issue_id_o    (issue_id),
    .issue_up_o    (issue_up),
    .issue_vd_o    (issue_vd),
    .issue_off_o   (issue_off),
    .issue_bytes_o (issue_bytes),
    .issue_done_i  (issue_done),
    .commit_valid_i(commit_valid),
    .commit_id_i   (commit_id),
    .done_o        (done_o),
    .done_id_o     (done_id_o)
  );

  sldu_execute #(
    .NrLanes(NrLanes)
  ) i_execute (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .issue_valid_i  (issue_valid),
    .issue_id_i     (issue_id),
    .issue_up_i     (issue_up),
    .issue_vd_i     (issue_vd),
    .issue_off_i    (issue_off),
    .issue_bytes_i  (issue_bytes),
    .issue_done_o   (issue_done),
    .operand_i      (operand_i),
    .operand_valid_i(operand_valid_i),
    .operand_ready_o(operand_ready_o),
    .push_valid_o   (push_valid),
    .push_ready_i   (push_ready),
    .push_id_o      (push_id),
    .push_addr_o    (push_addr),
    .push_wdata_o   (push_wdata),
    .push_be_o      (push_be),
    .push_last_o    (push_last)
  );

  sldu_result #(
    .NrLanes(NrLanes)
  ) i_result (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .push_valid_i  (push_valid),
    .push_ready_o  (push_ready),
    .push_id_i     (push_id),
    .push_addr_i   (push_addr),
    .push_wdata_i  (push_wdata),
    .push_be_i     (push_be),
    .push_last_i   (push_last),
    .res_valid_o   (res_valid_o),
    .res_ready_i   (res_ready_i),
    .res_id_o      (res_id_o),
    .res_addr_o    (res_addr_o),
    .res_wdata_o   (res_wdata_o),
    .res_be_o      (res_be_o),
    .commit_valid_o(commit_valid),
    .commit_id_o   (commit_id)
  );

endmodule

/* tb.f */
common/sldu_pkg.sv
sldu/sldu_decode.sv
sldu/sldu_execute.sv
sldu/sldu_result.sv
sldu/sldu_top.sv
tests/sldu_sva.sv
tests/tb_sldu.sv

/* tests/sldu_sva.sv */
`timescale 1ns/1ps
// Protocol assertions on the slide unit top level
// Result word stability, done timing, idle result channel after reset

module sldu_sva #(
  parameter int unsigned NrLanes = 4
) (
  input logic                          clk_i,
  input logic                          rst_ni,
  input logic                          res_valid_i,
  input logic                          res_ready_i,
  input sldu_pkg::vid_t                res_id_i,
  input sldu_pkg::vaddr_t              res_addr_i,
  input sldu_pkg::elen_t [NrLanes-1:0] res_wdata_i,
  input sldu_pkg::strb_t [NrLanes-1:0] res_be_i,
  input logic                          done_i
);

  // A waiting result word keeps its payload until taken
  a_res_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    res_valid_i && !res_ready_i |=> res_valid_i && $stable(res_id_i)
      && $stable(res_addr_i) && $stable(res_wdata_i) && $stable(res_be_i))
    else $error("result word changed before it was accepted");

  // Done follows the handshake of a result word by one cycle
  a_done_timing: assert property (@(posedge clk_i) disable iff (!rst_ni)
    done_i |-> $past(res_valid_i && res_ready_i))
    else $error("done pulse without a result handshake in the cycle before");

  // Nothing pending right after reset
  a_reset_idle: assert property (@(posedge clk_i)
    $rose(rst_ni) |-> !res_valid_i && !done_i)
    else $error("result channel or done active right after reset");

endmodule

bind sldu_top sldu_sva #(
  .NrLanes(NrLanes)
) i_sva (
  .clk_i      (clk_i),
  .rst_ni     (rst_ni),
  .res_valid_i(res_valid_o),
  .res_ready_i(res_ready_i),
  .res_id_i   (res_id_o),
  .res_addr_i (res_addr_o),
  .res_wdata_i(res_wdata_o),
  .res_be_i   (res_be_o),
  .done_i     (done_o)
);

/* tests/tb_sldu.sv */
`timescale 1ns/1ps
// Testbench of the vector slide unit
// LFSR stimulus, byte-level reference model of slide-up and slide-down,
// compare tasks and the closing report

module tb_sldu;

  import sldu_pkg::*;

  localparam int unsigned NrLanes        = 4;
  localparam int unsigned InsnQueueDepth = 4;
  // Bytes in one full word across all lanes
  localparam int          W              = 8 * NrLanes;
  localparam int          NumInsn        = 32;
  localparam int          SrcBytes       = 1024;
  localparam int          Timeout        = 20000;

  typedef logic [8*W-1:0] word_t;
  typedef logic [W-1:0]   wbe_t;

  logic                  clk_i;
  logic                  rst_ni;
  logic                  req_valid_i;
  logic                  req_ready_o;
  vid_t                  req_id_i;
  logic                  req_up_i;
  vaddr_t                req_vd_i;
  vlen_t                 req_vl_i;
  vlen_t                 req_stride_i;
  sew_t                  req_sew_i;
  logic                  operand_valid_i;
  elen_t [NrLanes-1:0]   operand_i;
  logic                  operand_ready_o;
  logic                  res_valid_o;
  vid_t                  res_id_o;
  vaddr_t                res_addr_o;
  elen_t [NrLanes-1:0]   res_wdata_o;
  strb_t [NrLanes-1:0]   res_be_o;
  logic                  res_ready_i;
  logic                  done_o;
  vid_t                  done_id_o;

  // Random source vector and the instruction list
  logic [7:0]  src_mem     [SrcBytes];
  logic        insn_up     [NumInsn];
  sew_t        insn_sew    [NumInsn];
  vlen_t       insn_vl     [NumInsn];
  vlen_t       insn_stride [NumInsn];
  vaddr_t      insn_vd     [NumInsn];
  int          insn_start  [NumInsn];
  int          insn_words  [NumInsn];

  // Expected result words in request order
  vaddr_t      exp_addr_q [$];
  vid_t        exp_id_q   [$];
  word_t       exp_data_q [$];
  wbe_t        exp_be_q   [$];
  vid_t        exp_done_q [$];

  logic [31:0] lfsr_q;
  int          req_idx;
  int          req_end;
  int          done_cnt;
  int          pending;
  int          fi;
  int          fw;
  int          stretch;
  int          word_cnt;
  int          err_val;
  int          err_other;
  logic        req_fire;
  logic        op_fire;
  logic        bp_mode;
  logic        full_seen;

  sldu_top #(
    .NrLanes       (NrLanes),
    .InsnQueueDepth(InsnQueueDepth)
  ) DUT (.*);

  initial begin
    clk_i = 1'b0;
    forever begin
      #10 clk_i = ~clk_i;
    end
  end

  // Galois LFSR, one step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    logic        b;
    r = '0;
    for (int i = 0; i < n; i++) begin
      b      = lfsr_q[0];
      lfsr_q = lfsr_q >> 1;
      if (b) begin
        lfsr_q = lfsr_q ^ 32'hA3000000;
      end
      r = {r[30:0], b};
    end
    return r;
  endfunction

  // Source word j in the linear byte layout
  function automatic word_t src_word(input int j);
    word_t w;
    for (int p = 0; p < W; p++) begin
      w[8*p +: 8] = src_mem[j*W + p];
    end
    return w;
  endfunction

  function automatic elen_t byte_mask(input strb_t be);
    elen_t m;
    for (int i = 0; i < ElenBytes; i++) begin
      m[8*i +: 8] = {8{be[i]}};
    end
    return m;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Compare tasks
  //////////////////////////////////////////////////////////////////////

  task automatic check_data(input string name, input elen_t exp, input elen_t act);
    if (act !== exp) begin
      err_val++;
      $display("Error %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_be(input string name, input strb_t exp, input strb_t act);
    if (act !== exp) begin
      err_val++;
      $display("Error %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  task automatic check_addr(input string name, input vaddr_t exp, input vaddr_t act);
    if (act !== exp) begin
      err_val++;
      $display("Error %s: expected %0d, actual %0d", name, exp, act);
    end
  endtask

  task automatic check_id(input string name, input vid_t exp, input vid_t act);
    if (act !== exp) begin
      err_val++;
      $display("Error %s: expected %0d, actual %0d", name, exp, act);
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      err_val++;
      $display("Error %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////////////////////////

  task automatic build_insn(input int k);
    int    size;
    int    off;
    int    total;
    int    bytes;
    int    src0;
    int    dst0;
    int    d;
    word_t data;
    wbe_t  be;
    // Each sew in both directions, twice per group of 16
    insn_sew[k]    = sew_t'(k % 4);
    insn_up[k]     = ((k / 4) % 2) == 0;
    insn_vl[k]     = vlen_t'(2 + rand_bits(5));
    insn_stride[k] = vlen_t'(rand_bits(6) % insn_vl[k]);
    insn_vd[k]     = vaddr_t'(rand_bits(8));
    size  = 1 << (k % 4);
    off   = insn_stride[k] * size;
    total = insn_vl[k] * size;
    // Slide-up writes from the offset, slide-down reads from it
    src0  = insn_up[k] ? 0 : off;
    dst0  = insn_up[k] ? off : 0;
    bytes = total - dst0;
    insn_start[k] = src0 / W;
    insn_words[k] = (src0 + bytes - 1) / W - src0 / W + 1;
    for (int w = dst0 / W; w <= (total - 1) / W; w++) begin
      data = '0;
      be   = '0;
      for (int p = 0; p < W; p++) begin
        d = w * W + p;
        if (d >= dst0 && d < total) begin
          be[p]          = 1'b1;
          data[8*p +: 8] = src_mem[src0 + d - dst0];
        end
      end
      exp_addr_q.push_back(vaddr_t'(insn_vd[k] + w));
      exp_id_q.push_back(vid_t'(k % NrVInsn));
      exp_data_q.push_back(data);
      exp_be_q.push_back(be);
    end
    exp_done_q.push_back(vid_t'(k % NrVInsn));
  endtask

  task automatic compare_result();
    word_t ed;
    wbe_t  eb;
    elen_t em;
    string name;
    if (exp_addr_q.size() == 0) begin
      err_other++;
      $display("Result word at address %0d arrived with nothing left to expect", res_addr_o);
    end else begin
      name = $sformatf("word %0d", word_cnt);
      check_addr({name, " addr"}, exp_addr_q.pop_front(), res_addr_o);
      check_id({name, " id"}, exp_id_q.pop_front(), res_id_o);
      ed = exp_data_q.pop_front();
      eb = exp_be_q.pop_front();
      for (int l = 0; l < NrLanes; l++) begin
        check_be($sformatf("%s lane %0d be", name, l), eb[8*l +: 8], res_be_o[l]);
        // Disabled bytes carry no meaning
        em = byte_mask(eb[8*l +: 8]);
        check_data($sformatf("%s lane %0d data", name, l), ed[64*l +: 64] & em,
                   res_wdata_o[l] & em);
      end
    end
    word_cnt++;
  endtask

  //////////////////////////////////////////////////////////////////////
  // One clock cycle of stimulus and monitoring
  //////////////////////////////////////////////////////////////////////

  task automatic cycle_step();
    @(negedge clk_i);
    // Transfers of the last rising edge
    if (req_fire) begin
      req_idx++;
      pending++;
    end
    if (op_fire) begin
      fw++;
      if (fw == insn_words[fi]) begin
        fi++;
        fw = 0;
      end
    end
    // Request valid held until accepted
    if (!req_valid_i || req_fire) begin
      req_valid_i = (req_idx < req_end) && (bp_mode || rand_bits(1) == 1);
      if (req_idx < NumInsn) begin
        req_id_i     = vid_t'(req_idx % NrVInsn);
        req_up_i     = insn_up[req_idx];
        req_vd_i     = insn_vd[req_idx];
        req_vl_i     = insn_vl[req_idx];
        req_stride_i = insn_stride[req_idx];
        req_sew_i    = insn_sew[req_idx];
      end
    end
    // Lanes feed consecutive source words of accepted instructions
    if (!operand_valid_i || op_fire) begin
      operand_valid_i = (fi < req_idx) && (rand_bits(2) != 0);
      if (fi < NumInsn) begin
        operand_i = src_word(insn_start[fi] + fw);
      end else begin
        operand_i = '0;
      end
    end
    // Long low stretches of res_ready_i under back-pressure
    if (stretch == 0) begin
      if (bp_mode) begin
        res_ready_i = rand_bits(1);
        stretch     = res_ready_i ? 1 + rand_bits(3) : 8 + rand_bits(5);
      end else begin
        res_ready_i = (rand_bits(2) != 0);
        stretch     = 1 + rand_bits(2);
      end
    end
    stretch--;
    // Everything below stays stable until the next rising edge
    #1;
    req_fire = req_valid_i && req_ready_o;
    op_fire  = operand_valid_i && operand_ready_o;
    if (done_o) begin
      pending--;
      done_cnt++;
      if (exp_done_q.size() == 0) begin
        err_other++;
        $display("done_o pulsed with no instruction outstanding");
      end else begin
        check_id($sformatf("done %0d id", done_cnt), exp_done_q.pop_front(), done_id_o);
      end
    end
    check_flag($sformatf("req_ready with %0d pending", pending), pending < InsnQueueDepth,
               req_ready_o);
    if (!req_ready_o) begin
      full_seen = 1'b1;
    end
    if (res_valid_o && res_ready_i) begin
      compare_result();
    end
  endtask

  task automatic run_phase(input int last, input logic bp);
    int cycles;
    req_end = last;
    bp_mode = bp;
    cycles  = 0;
    while (done_cnt < last && cycles < Timeout) begin
      cycle_step();
      cycles++;
    end
    if (done_cnt < last) begin
      err_other++;
      $display("Timeout: only %0d of %0d instructions finished after %0d cycles",
               done_cnt, last, cycles);
    end
  endtask

  initial begin
    lfsr_q          = 32'h94ed06c1;
    rst_ni          = 1'b0;
    req_valid_i     = 1'b0;
    req_id_i        = '0;
    req_up_i        = 1'b0;
    req_vd_i        = '0;
    req_vl_i        = '0;
    req_stride_i    = '0;
    req_sew_i       = '0;
    operand_valid_i = 1'b0;
    operand_i       = '0;
    res_ready_i     = 1'b0;
    req_idx   = 0;
    req_end   = 0;
    done_cnt  = 0;
    pending   = 0;
    fi        = 0;
    fw        = 0;
    stretch   = 0;
    word_cnt  = 0;
    err_val   = 0;
    err_other = 0;
    req_fire  = 1'b0;
    op_fire   = 1'b0;
    bp_mode   = 1'b0;
    full_seen = 1'b0;
    for (int i = 0; i < SrcBytes; i++) begin
      src_mem[i] = rand_bits(8);
    end
    for (int k = 0; k < NumInsn; k++) begin
      build_insn(k);
    end
    repeat (4) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    #1;
    // Idle outputs after reset
    check_flag("reset req_ready", 1'b1, req_ready_o);
    check_flag("reset operand_ready", 1'b0, operand_ready_o);
    check_flag("reset res_valid", 1'b0, res_valid_o);
    check_flag("reset done", 1'b0, done_o);
    run_phase(NumInsn / 2, 1'b0);
    full_seen = 1'b0;
    run_phase(NumInsn, 1'b1);
    if (!full_seen) begin
      err_other++;
      $display("Request queue never filled while results were held back");
    end
    if (exp_addr_q.size() != 0 || exp_done_q.size() != 0) begin
      err_other++;
      $display("%0d result words and %0d done reports never arrived",
               exp_addr_q.size(), exp_done_q.size());
    end
    $display("Errors: %0d value mismatches, %0d other failures", err_val, err_other);
    if (err_val == 0 && err_other == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule
